/* verification/bus_trace.txt */
# op (0 read, 1 write, 2 write strobe sent while busy with the next command), address, wdata,
# mask, uart reply data, expected rdata, expected err; all fields hex.
1 10000000 11223344 f 00000000 00000000 0
1 10000004 a5a5a5a5 f 00000000 00000000 0
1 10000008 deadbeef f 00000000 00000000 0
1 1000003c 01020304 f 00000000 00000000 0
1 10000000 000000ff 1 00000000 00000000 0
1 10000004 12345678 6 00000000 00000000 0
1 10000008 00000000 8 00000000 00000000 0
1 10000010 cafef00d a 00000000 00000000 0
0 10000000 00000000 0 00000000 112233ff 0
0 10000004 00000000 0 00000000 a53456a5 0
0 10000008 00000000 0 00000000 00adbeef 0
0 1000003c 00000000 0 00000000 01020304 0
0 10000010 00000000 0 00000000 ca00f000 0
0 1000000c 00000000 0 00000000 00000000 0
1 20000100 87654321 f 00000000 00000000 0
1 2abcdef4 0000beef 3 00000000 00000000 0
0 20000200 00000000 f 5a5a1234 5a5a1234 0
0 2fffff00 00000000 c 0badf00d 0badf00d 0
1 30000004 ffffffff f 00000000 00000000 1
0 00000000 00000000 f 00000000 00000000 1
1 f0000000 12345678 f 00000000 00000000 1
0 10000000 00000000 0 00000000 112233ff 0
0 10000004 00000000 0 00000000 a53456a5 0
1 10000014 55555555 f 00000000 00000000 0
2 10000014 77777777 f 00000000 00000000 0
1 10000018 66666666 f 00000000 00000000 0
0 10000014 00000000 0 00000000 55555555 0
0 10000018 00000000 0 00000000 66666666 0
2 20000300 13572468 f 00000000 00000000 0
0 20000400 00000000 f 2468ace0 2468ace0 0

/* filelist.f */
+incdir+src
src/bus_pkg.sv
src/wishbone_master.sv
src/bus_decoder.sv
src/wishbone_slave.sv
src/scratch_mem.sv
src/bus_top.sv
verification/bus_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the system bus testbench with Verilator and runs it from the project root.
# The exit status is the simulator's, so a failing run returns nonzero.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal -f filelist.f --top-module bus_tb -o bus_sim \
    && ./obj_dir/bus_sim \
    || { echo "bus simulation did not pass"; exit 1; }

/* verification/bus_tb.sv */
// testbench for the system bus; replays the command trace, models the uart device, checks results.
`timescale 1ns/100ps
`include "bus_params.svh"

module bus_tb import bus_pkg::*; ();

    localparam int          WAIT_LIMIT = 64;
    localparam logic [31:0] RAND_SEED  = 32'h7d7427dd;
    localparam logic [3:0]  OP_WRITE   = 4'h1;
    localparam logic [3:0]  OP_IGNORED = 4'h2;

    logic        clk_i = 1'b0;
    logic        rst_n_i;
    logic        cmd_valid_i;
    cmd_req_t    cmd_req_i;
    logic        busy_o;
    cmd_rsp_t    cmd_rsp_o;
    dev_req_t    uart_req_o;
    dev_rsp_t    uart_rsp_i = '0;

    dev_req_t    exp_uart_req;       // next request the uart should see.
    logic [31:0] uart_reply;
    int          uart_req_cnt = 0;
    int          busy_left = 0;
    int          reply_left = 0;

    bus_top uut (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .cmd_valid_i (cmd_valid_i),
        .cmd_req_i   (cmd_req_i),
        .busy_o      (busy_o),
        .cmd_rsp_o   (cmd_rsp_o),
        .uart_req_o  (uart_req_o),
        .uart_rsp_i  (uart_rsp_i)
    );

    always #4 clk_i = ~clk_i;

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1, "run stopped on the first error");
    endtask

    task automatic expect_level(input logic act, input logic exp, input string what);
        if (act !== exp) begin
            stop_on_error($sformatf("Mismatch at %0t: %s is %b, expected %b",
                                    $time, what, act, exp));
        end
    endtask

    task automatic expect_count(input int act, input int exp, input string what);
        if (act != exp) begin
            stop_on_error($sformatf("Mismatch at %0t: %s is %0d, expected %0d",
                                    $time, what, act, exp));
        end
    endtask

    task automatic check_cmd_rsp(input cmd_rsp_t act, input cmd_rsp_t exp);
        if (act !== exp) begin
            stop_on_error($sformatf("Mismatch at %0t: result rdata %h err %b, expected %h err %b",
                                    $time, act.rdata, act.err, exp.rdata, exp.err));
        end
    endtask

    task automatic check_dev_req(input dev_req_t act, input dev_req_t exp);
        if (act !== exp) begin
            stop_on_error($sformatf("Mismatch at %0t: uart request %h, expected %h",
                                    $time, act, exp));
        end
    endtask

    task automatic wait_idle();
        int cycles;
        cycles = 0;
        while (busy_o && cycles < WAIT_LIMIT) begin
            @(negedge clk_i);
            cycles++;
        end
        if (busy_o) begin
            stop_on_error("timeout: busy_o stayed high after a command");
        end
    endtask

    // one command, optionally followed by a strobe that must be ignored.
    task automatic run_cmd(input cmd_req_t cmd, input logic [31:0] reply, input logic with_ig,
                           input cmd_req_t ig_cmd, input cmd_rsp_t exp_rsp);
        int cnt_before;
        int exp_cnt;
        exp_uart_req.valid = 1'b1;
        exp_uart_req.we    = cmd.we;
        exp_uart_req.addr  = cmd.addr[27:0];
        exp_uart_req.wdata = cmd.wdata;
        exp_uart_req.mask  = cmd.mask;
        uart_reply = reply;
        cnt_before = uart_req_cnt;
        exp_cnt    = (cmd.addr[31:28] == `BUS_UART_REGION) ? 1 : 0;
        @(posedge clk_i);
        cmd_valid_i <= 1'b1;
        cmd_req_i   <= cmd;
        @(posedge clk_i);
        if (with_ig) begin
            cmd_req_i <= ig_cmd; // strobe stays up into the busy window.
        end else begin
            cmd_valid_i <= 1'b0;
        end
        @(negedge clk_i);
        expect_level(busy_o, 1'b1, "busy_o after accept");
        if (with_ig) begin
            @(posedge clk_i);
            cmd_valid_i <= 1'b0;
            @(negedge clk_i);
        end
        wait_idle();
        check_cmd_rsp(cmd_rsp_o, exp_rsp);
        expect_count(uart_req_cnt - cnt_before, exp_cnt, "uart requests for one command");
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // uart device model.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always @(posedge clk_i) begin
        if (!rst_n_i) begin
            uart_rsp_i <= '0;
            busy_left  = 0;
            reply_left = 0;
        end else begin
            uart_rsp_i.rdata_valid <= 1'b0;
            if (cmd_valid_i) begin
                busy_left = $urandom % 4; // busy window ahead of the request.
            end else if (busy_left != 0) begin
                busy_left = busy_left - 1;
            end
            uart_rsp_i.busy <= (busy_left != 0);
            if (uart_req_o.valid === 1'b1) begin
                check_dev_req(uart_req_o, exp_uart_req);
                uart_req_cnt = uart_req_cnt + 1;
                if (!uart_req_o.we) begin
                    reply_left = 1 + $urandom % 4;
                end
            end else if (reply_left != 0) begin
                reply_left = reply_left - 1;
                if (reply_left == 0) begin
                    uart_rsp_i.rdata_valid <= 1'b1;
                    uart_rsp_i.rdata       <= uart_reply;
                end
            end
        end
    end

    initial begin
        int          fd;
        int          n_cmds;
        string       line;
        logic [3:0]  op;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  mask;
        logic [31:0] reply;
        logic [31:0] exp_rdata;
        logic        exp_err;
        logic        ig_pending;
        cmd_req_t    cmd;
        cmd_req_t    ig_cmd;
        cmd_rsp_t    exp_rsp;
        void'($urandom(RAND_SEED));
        rst_n_i     = 1'b0;
        cmd_valid_i = 1'b0;
        cmd_req_i   = '0;
        ig_pending  = 1'b0;
        ig_cmd      = '0;
        n_cmds      = 0;
        repeat (2) @(posedge clk_i);
        rst_n_i <= 1'b1;
        @(negedge clk_i);
        expect_level(busy_o, 1'b0, "busy_o after reset");
        expect_level(uart_req_o.valid, 1'b0, "uart request valid after reset");

        fd = $fopen("verification/bus_trace.txt", "r");
        if (fd == 0) begin
            stop_on_error("could not open the trace file verification/bus_trace.txt");
        end
        while (!$feof(fd)) begin
            if ($fgets(line, fd) == 0) begin
                break;
            end
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            if ($sscanf(line, "%h %h %h %h %h %h %h", op, addr, wdata, mask, reply,
                        exp_rdata, exp_err) != 7) begin
                stop_on_error($sformatf("trace line could not be read: %s", line));
            end
            cmd.we      = (op == OP_WRITE) || (op == OP_IGNORED);
            cmd.addr    = addr;
            cmd.wdata   = wdata;
            cmd.mask    = mask;
            if (op == OP_IGNORED) begin
                ig_cmd     = cmd;   // rides along with the next command.
                ig_pending = 1'b1;
            end else begin
                exp_rsp.rdata = exp_rdata;
                exp_rsp.err   = exp_err;
                run_cmd(cmd, reply, ig_pending, ig_cmd, exp_rsp);
                ig_pending = 1'b0;
                n_cmds++;
            end
        end
        $fclose(fd);
        if (n_cmds == 0) begin
            stop_on_error("the trace held no commands");
        end else begin
            $display("STATUS: PASS");
            $finish;
        end
    end

endmodule

/* src/bus_top.sv */
// system bus top level joining master, decoder, memory and uart bridges; exposes the uart port.
`timescale 1ns/100ps

module bus_top import bus_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_n_i,

    // core side.
    input  logic     cmd_valid_i,
    input  cmd_req_t cmd_req_i,
    output logic     busy_o,
    output cmd_rsp_t cmd_rsp_o,

    // uart device port.
    output dev_req_t uart_req_o,
    input  dev_rsp_t uart_rsp_i
);

    wb_req_t  mst_wb_req;
    wb_rsp_t  mst_wb_rsp;
    wb_req_t  mem_wb_req;
    wb_rsp_t  mem_wb_rsp;
    wb_req_t  uart_wb_req;
    wb_rsp_t  uart_wb_rsp;
    dev_req_t mem_dev_req;
    dev_rsp_t mem_dev_rsp;

    wishbone_master master (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .cmd_valid_i (cmd_valid_i),
        .cmd_req_i   (cmd_req_i),
        .busy_o      (busy_o),
        .cmd_rsp_o   (cmd_rsp_o),
        .wb_req_o    (mst_wb_req),
        .wb_rsp_i    (mst_wb_rsp)
    );

    bus_decoder decoder (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .wb_req_i   (mst_wb_req),
        .wb_rsp_o   (mst_wb_rsp),
        .mem_req_o  (mem_wb_req),
        .mem_rsp_i  (mem_wb_rsp),
        .uart_req_o (uart_wb_req),
        .uart_rsp_i (uart_wb_rsp)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // device bridges.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    wishbone_slave mem_bridge (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .wb_req_i  (mem_wb_req),
        .wb_rsp_o  (mem_wb_rsp),
        .dev_req_o (mem_dev_req),
        .dev_rsp_i (mem_dev_rsp)
    );

    scratch_mem mem (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .dev_req_i (mem_dev_req),
        .dev_rsp_o (mem_dev_rsp)
    );

    wishbone_slave uart_bridge (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .wb_req_i  (uart_wb_req),
        .wb_rsp_o  (uart_wb_rsp),
        .dev_req_o (uart_req_o),
        .dev_rsp_i (uart_rsp_i)
    );

endmodule

/* src/scratch_mem.sv */
// scratch memory device with byte masks and fixed read latency, placed behind a bus bridge.
`timescale 1ns/100ps
`include "bus_params.svh"

module scratch_mem import bus_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_n_i,
    input  dev_req_t dev_req_i,
    output dev_rsp_t dev_rsp_o
);

    localparam int IDX_W = $clog2(`BUS_MEM_WORDS);
    localparam int CNT_W = $clog2(`BUS_MEM_RD_LAT + 1);

    logic [31:0]      mem_q [`BUS_MEM_WORDS];
    logic [IDX_W-1:0] word_idx;
    logic [IDX_W-1:0] rd_idx_q;
    logic [CNT_W-1:0] lat_cnt_q;   // read cycles left.

    assign word_idx = dev_req_i.addr[IDX_W+1:2]; // word aligned.

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `BUS_MEM_WORDS; i++) begin
                mem_q[i] <= '0;
            end
            lat_cnt_q <= '0;
        end else begin
            if (dev_req_i.valid && dev_req_i.we) begin
                for (int b = 0; b < 4; b++) begin
                    if (dev_req_i.mask[b]) begin
                        mem_q[word_idx][8*b +: 8] <= dev_req_i.wdata[8*b +: 8];
                    end
                end
            end
            if (dev_req_i.valid && !dev_req_i.we) begin
                lat_cnt_q <= CNT_W'(`BUS_MEM_RD_LAT);
            end else if (lat_cnt_q != '0) begin
                lat_cnt_q <= lat_cnt_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (dev_req_i.valid && !dev_req_i.we) begin
            rd_idx_q <= word_idx;
        end
    end

    assign dev_rsp_o.busy        = (lat_cnt_q != '0);
    assign dev_rsp_o.rdata_valid = (lat_cnt_q == CNT_W'(1)); // last latency cycle.
    assign dev_rsp_o.rdata       = mem_q[rd_idx_q];

endmodule

/* src/wishbone_slave.sv */
// bus bridge from one wishbone region to a device request/response port with busy and read-valid.
`timescale 1ns/100ps

module wishbone_slave import bus_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_n_i,

    input  wb_req_t  wb_req_i,
    output wb_rsp_t  wb_rsp_o,

    output dev_req_t dev_req_o,
    input  dev_rsp_t dev_rsp_i
);

    slv_state_e  state_q;
    slv_state_e  state_d;
    logic [31:0] rdata_q;   // read word from the device.
    logic        bus_act;

    assign bus_act = wb_req_i.cyc && wb_req_i.stb;

    always_comb begin
        state_d = state_q;
        case (state_q)
            SLV_IDLE: begin
                if (bus_act) begin
                    state_d = SLV_ISSUE;
                end
            end
            SLV_ISSUE: begin
                // stall here while the device is busy.
                if (!dev_rsp_i.busy) begin
                    state_d = wb_req_i.we ? SLV_ACK : SLV_WAIT_RD;
                end
            end
            SLV_WAIT_RD: begin
                if (dev_rsp_i.rdata_valid) begin
                    state_d = SLV_ACK;
                end
            end
            SLV_ACK: begin
                if (!bus_act) begin
                    state_d = SLV_IDLE; // wait for stb to drop before the next cycle.
                end
            end
            default: begin
                state_d = SLV_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= SLV_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == SLV_WAIT_RD && dev_rsp_i.rdata_valid) begin
            rdata_q <= dev_rsp_i.rdata;
        end
    end

    // single request per bus cycle.
    assign dev_req_o.valid = (state_q == SLV_ISSUE) && !dev_rsp_i.busy;
    assign dev_req_o.we    = wb_req_i.we;
    assign dev_req_o.addr  = wb_req_i.addr[27:0];
    assign dev_req_o.wdata = wb_req_i.wdata;
    assign dev_req_o.mask  = wb_req_i.sel;

    assign wb_rsp_o.ack   = (state_q == SLV_ACK) && bus_act;
    assign wb_rsp_o.err   = 1'b0;
    assign wb_rsp_o.rdata = rdata_q;

endmodule

/* src/bus_decoder.sv */
// address decoder that routes each bus cycle to one bridge and answers unmapped cycles with err.
`timescale 1ns/100ps
`include "bus_params.svh"

module bus_decoder import bus_pkg::*; (
    input  logic    clk_i,
    input  logic    rst_n_i,

    input  wb_req_t wb_req_i,
    output wb_rsp_t wb_rsp_o,

    output wb_req_t mem_req_o,
    input  wb_rsp_t mem_rsp_i,
    output wb_req_t uart_req_o,
    input  wb_rsp_t uart_rsp_i
);

    region_e region;
    logic    bus_act;
    logic    err_ack_q;

    assign bus_act = wb_req_i.cyc && wb_req_i.stb;

    always_comb begin
        if (wb_req_i.addr[31:28] == `BUS_MEM_REGION) begin
            region = REG_MEM;
        end else if (wb_req_i.addr[31:28] == `BUS_UART_REGION) begin
            region = REG_UART;
        end else begin
            region = REG_NONE;
        end
    end

    // only the selected bridge sees cyc and stb.
    always_comb begin
        mem_req_o      = wb_req_i;
        mem_req_o.cyc  = wb_req_i.cyc && (region == REG_MEM);
        mem_req_o.stb  = wb_req_i.stb && (region == REG_MEM);
        uart_req_o     = wb_req_i;
        uart_req_o.cyc = wb_req_i.cyc && (region == REG_UART);
        uart_req_o.stb = wb_req_i.stb && (region == REG_UART);
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            err_ack_q <= 1'b0;
        end else begin
            err_ack_q <= bus_act && (region == REG_NONE) && !err_ack_q; // one pulse.
        end
    end

    always_comb begin
        case (region)
            REG_MEM:  wb_rsp_o = mem_rsp_i;
            REG_UART: wb_rsp_o = uart_rsp_i;
            default: begin
                wb_rsp_o.ack   = err_ack_q;
                wb_rsp_o.err   = err_ack_q;
                wb_rsp_o.rdata = 32'h0;
            end
        endcase
    end

endmodule

/* src/wishbone_master.sv */
// bus master that turns one core command strobe into one wishbone cycle and returns the result.
`timescale 1ns/100ps

module wishbone_master import bus_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_n_i,

    input  logic     cmd_valid_i,
    input  cmd_req_t cmd_req_i,
    output logic     busy_o,
    output cmd_rsp_t cmd_rsp_o,

    output wb_req_t  wb_req_o,
    input  wb_rsp_t  wb_rsp_i
);

    mst_state_e state_q;
    mst_state_e state_d;
    cmd_req_t   cmd_q;   // command held for the whole cycle.
    cmd_rsp_t   rsp_q;
    logic       accept;

    assign busy_o = (state_q == MST_BUS);
    assign accept = cmd_valid_i && !busy_o; // strobes during busy are dropped.

    always_comb begin
        state_d = state_q;
        case (state_q)
            MST_IDLE: begin
                if (accept) begin
                    state_d = MST_BUS;
                end
            end
            MST_BUS: begin
                if (wb_rsp_i.ack) begin
                    state_d = MST_DONE;
                end
            end
            MST_DONE: begin
                state_d = accept ? MST_BUS : MST_IDLE;
            end
            default: begin
                state_d = MST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= MST_IDLE;
            rsp_q   <= '0;
        end else begin
            state_q <= state_d;
            if (busy_o && wb_rsp_i.ack) begin
                rsp_q.rdata <= cmd_q.we ? 32'h0 : wb_rsp_i.rdata;
                rsp_q.err   <= wb_rsp_i.err;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            cmd_q <= cmd_req_i;
        end
    end

    // cycle stays open until ack.
    assign wb_req_o.cyc   = busy_o;
    assign wb_req_o.stb   = busy_o;
    assign wb_req_o.we    = cmd_q.we;
    assign wb_req_o.addr  = cmd_q.addr;
    assign wb_req_o.wdata = cmd_q.wdata;
    assign wb_req_o.sel   = cmd_q.mask;

    assign cmd_rsp_o = rsp_q;

endmodule

/* src/bus_pkg.sv */
// shared bus types, imported by every module of the system bus and by the testbench.
package bus_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // core side.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef struct packed {
        logic        we;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  mask;   // byte enables.
    } cmd_req_t;

    typedef struct packed {
        logic [31:0] rdata;  // zero for writes.
        logic        err;
    } cmd_rsp_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // wishbone bus.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  sel;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic        err;
        logic [31:0] rdata;
    } wb_rsp_t;

    // device port behind a bridge.
    typedef struct packed {
        logic        valid;  // one cycle per request.
        logic        we;
        logic [27:0] addr;   // offset inside the region.
        logic [31:0] wdata;
        logic [3:0]  mask;
    } dev_req_t;

    typedef struct packed {
        logic        busy;
        logic        rdata_valid;
        logic [31:0] rdata;
    } dev_rsp_t;

    typedef enum logic [1:0] {MST_IDLE, MST_BUS, MST_DONE} mst_state_e;
    typedef enum logic [1:0] {SLV_IDLE, SLV_ISSUE, SLV_WAIT_RD, SLV_ACK} slv_state_e;
    typedef enum logic [1:0] {REG_NONE, REG_MEM, REG_UART} region_e;

endpackage

/* src/bus_params.svh */
// address map and scratch memory sizing, included by the bus RTL and the testbench.
`ifndef BUS_PARAMS_SVH
`define BUS_PARAMS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// address map, compared against addr[31:28].
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define BUS_MEM_REGION  4'h1 // scratch memory.
`define BUS_UART_REGION 4'h2 // uart device port.

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// scratch memory.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// depth in 32-bit words.
`define BUS_MEM_WORDS 16

// cycles from request valid to read data valid.
`define BUS_MEM_RD_LAT 2

`endif
